// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= list.f
TOP       ?= tb_udp_echo
RTL_TOP   ?= udp_echo_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL CHECKS PASSED
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/echo_ctrl.sv ====
// Every frame must carry at least one payload word, the last one flagged by pl_last
`timescale 1ns/1ps

module echo_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic rx_hdr_req,
    input  logic tx_hdr_ack,
    input  logic pl_req,
    input  logic pl_last,
    input  logic is_echo,
    input  logic word_done,
    output logic rx_hdr_ack,
    output logic tx_hdr_req,
    output logic pl_ack,
    output logic hdr_capture,
    output logic word_go,
    output logic frame_first
);
    import udp_echo_pkg::*;

    logic [ST_W-1:0] state;
    // Next word opens a frame
    logic            first_word;
    // Word in flight carries pl_last
    logic            last_word;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            rx_hdr_ack  <= 1'b0;
            tx_hdr_req  <= 1'b0;
            pl_ack      <= 1'b0;
            hdr_capture <= 1'b0;
            word_go     <= 1'b0;
            frame_first <= 1'b0;
            first_word  <= 1'b0;
            last_word   <= 1'b0;
        end else begin
            // Strobes are single cycle
            hdr_capture <= 1'b0;
            word_go     <= 1'b0;
            frame_first <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (rx_hdr_req) begin
                        hdr_capture <= 1'b1;
                        state       <= ST_CAPTURE;
                    end
                end

                // Header registers load at the end of this cycle
                ST_CAPTURE: begin
                    state <= ST_DECIDE;
                end

                ST_DECIDE: begin
                    if (is_echo) begin
                        tx_hdr_req <= 1'b1;
                        state      <= ST_REPLY;
                    end else begin
                        rx_hdr_ack <= 1'b1;
                        state      <= ST_FIN_HDR;
                    end
                end

                // Receive ack is held back until the reply is taken
                ST_REPLY: begin
                    if (tx_hdr_ack) begin
                        tx_hdr_req <= 1'b0;
                        rx_hdr_ack <= 1'b1;
                        state      <= ST_FIN_HDR;
                    end
                end

                // Both header handshakes return to zero
                ST_FIN_HDR: begin
                    if (!rx_hdr_req && !tx_hdr_ack) begin
                        rx_hdr_ack <= 1'b0;
                        first_word <= 1'b1;
                        state      <= ST_PL_WAIT;
                    end
                end

                ST_PL_WAIT: begin
                    if (pl_req) begin
                        word_go     <= 1'b1;
                        frame_first <= first_word;
                        last_word   <= pl_last;
                        state       <= ST_PL_STORE;
                    end
                end

                ST_PL_STORE: begin
                    if (word_done) begin
                        pl_ack <= 1'b1;
                        state  <= ST_PL_ACK;
                    end
                end

                ST_PL_ACK: begin
                    if (!pl_req) begin
                        pl_ack     <= 1'b0;
                        first_word <= 1'b0;
                        // New header only after the last word completes
                        state      <= last_word ? ST_IDLE : ST_PL_WAIT;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== hw/hdr_rewrite.sv ====
// Reply checksum is always zero; rx_hdr_word and rx_src_ip must be stable during hdr_capture
`timescale 1ns/1ps

module hdr_rewrite (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 hdr_capture,
    input  udp_echo_pkg::udp_hdr_u               rx_hdr_word,
    input  logic [udp_echo_pkg::IP_W-1:0]        rx_src_ip,
    output udp_echo_pkg::udp_hdr_u               tx_hdr_word,
    output logic [udp_echo_pkg::IP_W-1:0]        tx_dst_ip,
    output logic                                 is_echo
);
    import udp_echo_pkg::*;

    // Port match decides echo or drop
    always_ff @(posedge clk) begin
        if (rst) begin
            is_echo <= 1'b0;
        end else if (hdr_capture) begin
            is_echo <= (rx_hdr_word.fld.dst_port == ECHO_PORT);
        end
    end

    // Reply header goes back to the sender
    always_ff @(posedge clk) begin
        if (hdr_capture) begin
            tx_hdr_word.fld.src_port <= rx_hdr_word.fld.dst_port;
            tx_hdr_word.fld.dst_port <= rx_hdr_word.fld.src_port;
            tx_hdr_word.fld.length   <= rx_hdr_word.fld.length;
            tx_hdr_word.fld.checksum <= '0;
            tx_dst_ip                <= rx_src_ip;
        end
    end

endmodule

// ==== hw/payload_store.sv ====
// Writes at most MAX_WORDS words per frame; base_ptr of zero disables writes and must not change mid-frame
`timescale 1ns/1ps

module payload_store (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 word_go,
    input  logic                                 frame_first,
    input  logic [udp_echo_pkg::DATA_W-1:0]      pl_data,
    input  logic [udp_echo_pkg::ADDR_W-1:0]      base_ptr,
    input  logic                                 mem_ack,
    output logic                                 word_done,
    output logic                                 mem_req,
    output logic [udp_echo_pkg::ADDR_W-1:0]      mem_addr,
    output logic [udp_echo_pkg::DATA_W-1:0]      mem_data,
    output logic [udp_echo_pkg::LED_W-1:0]       led
);
    import udp_echo_pkg::*;

    // Words written so far in this frame
    logic [CNT_W-1:0] word_cnt;
    logic [CNT_W-1:0] cnt_eff;
    logic             write_ok;
    // Ack seen, waiting for it to drop
    logic             ack_seen;

    // First word of a frame counts from zero
    assign cnt_eff  = frame_first ? '0 : word_cnt;
    assign write_ok = (base_ptr != '0) && (cnt_eff < CNT_W'(MAX_WORDS));

    always_ff @(posedge clk) begin
        if (rst) begin
            word_cnt  <= '0;
            mem_req   <= 1'b0;
            ack_seen  <= 1'b0;
            word_done <= 1'b0;
            led       <= '0;
        end else begin
            word_done <= 1'b0;

            if (word_go) begin
                if (frame_first) begin
                    led <= pl_data[LED_W-1:0];
                end
                if (write_ok) begin
                    mem_req  <= 1'b1;
                    word_cnt <= cnt_eff + CNT_W'(1);
                end else begin
                    // Skipped write completes at once
                    word_done <= 1'b1;
                    word_cnt  <= cnt_eff;
                end
            end else if (mem_req && mem_ack) begin
                mem_req  <= 1'b0;
                ack_seen <= 1'b1;
            end else if (ack_seen && !mem_ack) begin
                ack_seen  <= 1'b0;
                word_done <= 1'b1;
            end
        end
    end

    // Write address and data, held until the next word
    always_ff @(posedge clk) begin
        if (word_go && write_ok) begin
            mem_addr <= base_ptr + ADDR_W'(cnt_eff * WORD_BYTES);
            mem_data <= pl_data;
        end
    end

endmodule

// ==== hw/udp_echo_pkg.sv ====
// One frame at a time; LOCAL_IP and ECHO_TTL describe the reply but drive no port of the engine
package udp_echo_pkg;

    // Datapath widths
    localparam int DATA_W = 64;
    localparam int PORT_W = 16;
    localparam int IP_W   = 32;
    localparam int ADDR_W = 32;
    localparam int LED_W  = 2;

    // Payload capture into external memory
    localparam int WORD_BYTES = 8;
    localparam int MAX_WORDS  = 8;
    localparam int CNT_W      = 4;

    // Echo service
    localparam logic [PORT_W-1:0] ECHO_PORT = 16'd1234;

    // Reply source address and TTL, applied by the IP layer downstream
    localparam logic [IP_W-1:0] LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam logic [7:0]      ECHO_TTL = 8'd64;

    // Controller state encoding
    localparam int ST_W = 3;
    localparam logic [ST_W-1:0] ST_IDLE     = 3'd0;
    localparam logic [ST_W-1:0] ST_CAPTURE  = 3'd1;
    localparam logic [ST_W-1:0] ST_DECIDE   = 3'd2;
    localparam logic [ST_W-1:0] ST_REPLY    = 3'd3;
    localparam logic [ST_W-1:0] ST_FIN_HDR  = 3'd4;
    localparam logic [ST_W-1:0] ST_PL_WAIT  = 3'd5;
    localparam logic [ST_W-1:0] ST_PL_STORE = 3'd6;
    localparam logic [ST_W-1:0] ST_PL_ACK   = 3'd7;

    // UDP header fields in wire order, source port in the top bits
    typedef struct packed {
        logic [PORT_W-1:0] src_port;
        logic [PORT_W-1:0] dst_port;
        logic [PORT_W-1:0] length;
        logic [PORT_W-1:0] checksum;
    } udp_hdr_t;

    // Same 64-bit header seen as one word or as fields
    typedef union packed {
        logic [DATA_W-1:0] raw;
        udp_hdr_t          fld;
    } udp_hdr_u;

endpackage

// ==== hw/udp_echo_top.sv ====
// All ports use four-phase req/ack; header, payload and memory sides are handled one frame at a time
`timescale 1ns/1ps

module udp_echo_top (
    input  logic                                 clk,
    input  logic                                 rst,
    // Receive header
    input  logic                                 rx_hdr_req,
    input  udp_echo_pkg::udp_hdr_u               rx_hdr_word,
    input  logic [udp_echo_pkg::IP_W-1:0]        rx_src_ip,
    output logic                                 rx_hdr_ack,
    // Transmit header
    output logic                                 tx_hdr_req,
    output udp_echo_pkg::udp_hdr_u               tx_hdr_word,
    output logic [udp_echo_pkg::IP_W-1:0]        tx_dst_ip,
    input  logic                                 tx_hdr_ack,
    // Payload
    input  logic                                 pl_req,
    input  logic [udp_echo_pkg::DATA_W-1:0]      pl_data,
    input  logic                                 pl_last,
    output logic                                 pl_ack,
    // Memory write
    output logic                                 mem_req,
    output logic [udp_echo_pkg::ADDR_W-1:0]      mem_addr,
    output logic [udp_echo_pkg::DATA_W-1:0]      mem_data,
    input  logic                                 mem_ack,
    input  logic [udp_echo_pkg::ADDR_W-1:0]      base_ptr,
    output logic [udp_echo_pkg::LED_W-1:0]       led
);

    logic hdr_capture;
    logic is_echo;
    logic word_go;
    logic frame_first;
    logic word_done;

    echo_ctrl ctrl0 (
        .clk         (clk),
        .rst         (rst),
        .rx_hdr_req  (rx_hdr_req),
        .tx_hdr_ack  (tx_hdr_ack),
        .pl_req      (pl_req),
        .pl_last     (pl_last),
        .is_echo     (is_echo),
        .word_done   (word_done),
        .rx_hdr_ack  (rx_hdr_ack),
        .tx_hdr_req  (tx_hdr_req),
        .pl_ack      (pl_ack),
        .hdr_capture (hdr_capture),
        .word_go     (word_go),
        .frame_first (frame_first)
    );

    hdr_rewrite rewrite0 (
        .clk         (clk),
        .rst         (rst),
        .hdr_capture (hdr_capture),
        .rx_hdr_word (rx_hdr_word),
        .rx_src_ip   (rx_src_ip),
        .tx_hdr_word (tx_hdr_word),
        .tx_dst_ip   (tx_dst_ip),
        .is_echo     (is_echo)
    );

    payload_store store0 (
        .clk         (clk),
        .rst         (rst),
        .word_go     (word_go),
        .frame_first (frame_first),
        .pl_data     (pl_data),
        .base_ptr    (base_ptr),
        .mem_ack     (mem_ack),
        .word_done   (word_done),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_data    (mem_data),
        .led         (led)
    );

endmodule

// ==== list.f ====
hw/udp_echo_pkg.sv
hw/echo_ctrl.sv
hw/hdr_rewrite.sv
hw/payload_store.sv
hw/udp_echo_top.sv
test/tb_udp_echo.sv

// ==== test/tb_udp_echo.sv ====
// Needs Verilator --timing and --assert; seed 31, and every wait gives up after 200 cycles
`timescale 1ns/1ps

module ack_responder (
    input  logic clk,
    input  logic rst,
    input  logic req,
    output logic ack
);
    logic ack_q = 1'b0;
    int   wait_n = 0;

    assign ack = ack_q;

    // Follows req after a random number of cycles, both edges
    always @(posedge clk) begin
        if (rst) begin
            ack_q  <= #1 1'b0;
            wait_n <= 0;
        end else if (req != ack_q) begin
            if (wait_n == 0) begin
                ack_q  <= #1 req;
                wait_n <= $urandom_range(0, 4);
            end else begin
                wait_n <= wait_n - 1;
            end
        end
    end
endmodule

module tb_udp_echo;
    import udp_echo_pkg::*;

    localparam int LIMIT = 200;

    logic              clk = 1'b0;
    logic              rst = 1'b1;
    logic              rx_hdr_req = 1'b0;
    udp_hdr_u          rx_hdr_word = '0;
    logic [IP_W-1:0]   rx_src_ip = '0;
    logic              rx_hdr_ack;
    logic              tx_hdr_req;
    udp_hdr_u          tx_hdr_word;
    logic [IP_W-1:0]   tx_dst_ip;
    logic              tx_hdr_ack;
    logic              pl_req = 1'b0;
    logic [DATA_W-1:0] pl_data = '0;
    logic              pl_last = 1'b0;
    logic              pl_ack;
    logic              mem_req;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_data;
    logic              mem_ack;
    logic [ADDR_W-1:0] base_ptr = '0;
    logic [LED_W-1:0]  led;

    // Expected values, set by the stimulus
    udp_hdr_u          exp_hdr = '0;
    logic [IP_W-1:0]   exp_ip = '0;
    logic              exp_echo = 1'b0;
    logic              exp_write = 1'b0;
    logic [ADDR_W-1:0] exp_addr = '0;
    logic [DATA_W-1:0] exp_data = '0;
    logic [LED_W-1:0]  exp_led = '0;
    int                echo_sent = 0;

    // Observed events
    int   tx_ack_rises = 0;
    int   writes_seen = 0;
    logic tx_ack_d = 1'b0;
    logic mem_req_d = 1'b0;
    logic rst_d = 1'b1;
    int   cyc = 0;

    int   errors = 0;
    int   err_start = 0;
    int   tests = 0;
    int   frames = 0;
    logic timed_out = 1'b0;

    always #2 clk = ~clk;

    udp_echo_top dut0 (.*);

    ack_responder tx_resp0 (.clk(clk), .rst(rst), .req(tx_hdr_req), .ack(tx_hdr_ack));
    ack_responder mem_resp0 (.clk(clk), .rst(rst), .req(mem_req), .ack(mem_ack));

    always @(posedge clk) begin
        cyc       <= cyc + 1;
        rst_d     <= rst;
        tx_ack_d  <= tx_hdr_ack;
        mem_req_d <= mem_req;
        if (tx_hdr_ack && !tx_ack_d) tx_ack_rises <= tx_ack_rises + 1;
        if (mem_req && !mem_req_d) writes_seen <= writes_seen + 1;
    end

    // Idle outputs during reset and the cycle after
    assert property (@(posedge clk) (cyc != 0 && (rst || rst_d)) |->
        (!rx_hdr_ack && !tx_hdr_req && !pl_ack && !mem_req && led == '0))
        else begin
            $display("Mismatch at %0t: {rx_hdr_ack,tx_hdr_req,pl_ack,mem_req,led} exp %b got %b",
                     $time, 6'b0, {rx_hdr_ack, tx_hdr_req, pl_ack, mem_req, led});
            errors++;
        end
    assert property (@(posedge clk) disable iff (rst) tx_hdr_req |-> exp_echo)
        else begin
            $display("Reply requested at %0t for a header off the echo port", $time);
            errors++;
        end
    assert property (@(posedge clk) disable iff (rst) tx_hdr_req |-> tx_hdr_word == exp_hdr)
        else begin
            $display("Mismatch at %0t: tx_hdr_word exp %h got %h", $time, exp_hdr, tx_hdr_word);
            errors++;
        end
    assert property (@(posedge clk) disable iff (rst) tx_hdr_req |-> tx_dst_ip == exp_ip)
        else begin
            $display("Mismatch at %0t: tx_dst_ip exp %h got %h", $time, exp_ip, tx_dst_ip);
            errors++;
        end
    // Echo header is acked only once its reply was taken
    assert property (@(posedge clk) disable iff (rst)
        (rx_hdr_ack && exp_echo) |-> tx_ack_rises == echo_sent)
        else begin
            $display("Receive header acked at %0t before the reply was taken", $time);
            errors++;
        end
    assert property (@(posedge clk) disable iff (rst) mem_req |-> exp_write)
        else begin
            $display("Memory write at %0t where none is due", $time);
            errors++;
        end
    assert property (@(posedge clk) disable iff (rst) (mem_req && exp_write) |->
        mem_addr == exp_addr)
        else begin
            $display("Mismatch at %0t: mem_addr exp %h got %h", $time, exp_addr, mem_addr);
            errors++;
        end
    assert property (@(posedge clk) disable iff (rst) (mem_req && exp_write) |->
        mem_data == exp_data)
        else begin
            $display("Mismatch at %0t: mem_data exp %h got %h", $time, exp_data, mem_data);
            errors++;
        end

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Polls rx_hdr_ack or pl_ack just after each edge; after a timeout no wait is made
    task automatic await_ack(input bit on_pl, input logic level, input string what);
        int n;
        n = 0;
        while (!timed_out && (on_pl ? pl_ack : rx_hdr_ack) !== level && n < LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!timed_out && (on_pl ? pl_ack : rx_hdr_ack) !== level) begin
            $display("Timeout at %0t while waiting for %s", $time, what);
            timed_out = 1'b1;
            errors++;
        end
    endtask

    function automatic logic [PORT_W-1:0] drop_port();
        logic [PORT_W-1:0] p;
        p = PORT_W'($urandom_range(0, 65535));
        if (p == ECHO_PORT) p = p + 16'd1;
        return p;
    endfunction

    function automatic logic [ADDR_W-1:0] rand_base();
        return ($urandom() & 32'hFFFF_FFF8) | 32'h0000_1000;
    endfunction

    // One header, then nwords payload words
    task automatic send_frame(input logic [PORT_W-1:0] dst, input logic [ADDR_W-1:0] base,
                              input int nwords);
        logic [PORT_W-1:0] src;
        logic [DATA_W-1:0] data;
        int                i;
        int                writes_at_start;
        int                want_writes;
        src      = PORT_W'($urandom_range(0, 65535));
        base_ptr = base;
        rx_hdr_word.fld.src_port = src;
        rx_hdr_word.fld.dst_port = dst;
        rx_hdr_word.fld.length   = PORT_W'(8 + 8 * nwords);
        rx_hdr_word.fld.checksum = PORT_W'($urandom());
        rx_src_ip = $urandom();
        // Ports swapped, length kept, checksum cleared
        exp_hdr.fld.src_port = dst;
        exp_hdr.fld.dst_port = src;
        exp_hdr.fld.length   = rx_hdr_word.fld.length;
        exp_hdr.fld.checksum = '0;
        exp_ip   = rx_src_ip;
        exp_echo = (dst == ECHO_PORT);
        if (exp_echo) echo_sent++;
        rx_hdr_req = 1'b1;
        await_ack(1'b0, 1'b1, "rx_hdr_ack to rise");
        rx_hdr_req = 1'b0;
        await_ack(1'b0, 1'b0, "rx_hdr_ack to fall");

        writes_at_start = writes_seen;
        want_writes     = 0;
        for (i = 0; i < nwords; i++) begin
            data = {$urandom(), $urandom()};
            if (i == 0) exp_led = data[LED_W-1:0];
            exp_write = (base != '0) && (i < MAX_WORDS);
            exp_addr  = base + ADDR_W'(i * WORD_BYTES);
            exp_data  = data;
            if (exp_write) want_writes++;
            pl_data = data;
            pl_last = (i == nwords - 1);
            pl_req  = 1'b1;
            await_ack(1'b1, 1'b1, "pl_ack to rise");
            pl_req = 1'b0;
            await_ack(1'b1, 1'b0, "pl_ack to fall");
        end
        // A stalled frame has no meaningful counts
        if (timed_out) return;
        assert (writes_seen - writes_at_start == want_writes) else begin
            $display("Mismatch at %0t: write count exp %0d got %0d", $time, want_writes,
                     writes_seen - writes_at_start);
            errors++;
        end
        assert (led == exp_led) else begin
            $display("Mismatch at %0t: led exp %b got %b", $time, exp_led, led);
            errors++;
        end
        frames++;
    endtask

    task automatic finish_test(input string name);
        $display("test %-10s done, %0d errors", name, errors - err_start);
        err_start = errors;
        tests++;
    endtask

    initial begin
        void'($urandom(31));
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        idle_cycles(2);
        finish_test("reset");
        repeat (4) send_frame(ECHO_PORT, rand_base(), 1 + $urandom_range(0, 3));
        finish_test("echo");
        repeat (4) send_frame(drop_port(), rand_base(), 1 + $urandom_range(0, 3));
        finish_test("drop");
        send_frame(ECHO_PORT, rand_base(), MAX_WORDS + 3);
        finish_test("word cap");
        send_frame(drop_port(), '0, 5);
        send_frame(ECHO_PORT, '0, 2);
        finish_test("zero base");
        // Mixed ports, bases and lengths, led checked per frame
        repeat (8) begin
            send_frame($urandom_range(0, 1) != 0 ? ECHO_PORT : drop_port(),
                       $urandom_range(0, 3) == 0 ? '0 : rand_base(),
                       1 + $urandom_range(0, 9));
        end
        finish_test("leds");
        $display("%0d tests, %0d frames, %0d errors", tests, frames, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
